//--- hw/hazardPkg.sv
package hazardPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int instrWidth = 32;
	localparam int regIdxW    = 5;
	localparam int clsWidth   = 2;
	localparam int useWidth   = 2;
	localparam int selWidth   = 4;

	// Link register written by jal
	localparam logic [regIdxW-1:0] regLink = 5'd31;

	// Bubble word and register reset contents
	localparam logic [instrWidth-1:0] instrNop = 32'h0000_0000;

	////////////////////////////////////////////////////////////
	// Opcode and funct encodings
	////////////////////////////////////////////////////////////

	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJal   = 6'h03;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// R-type funct field
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;

	////////////////////////////////////////////////////////////
	// Result class of the producing instruction
	////////////////////////////////////////////////////////////

	localparam logic [clsWidth-1:0] clsNone = 2'd0;
	localparam logic [clsWidth-1:0] clsAlu  = 2'd1;
	localparam logic [clsWidth-1:0] clsDm   = 2'd2;
	localparam logic [clsWidth-1:0] clsPc   = 2'd3;

	// Stage in which a source operand is first needed
	localparam logic [useWidth-1:0] useNow   = 2'd0;
	localparam logic [useWidth-1:0] useExe   = 2'd1;
	localparam logic [useWidth-1:0] useMem   = 2'd2;
	localparam logic [useWidth-1:0] useNever = 2'd3;

	////////////////////////////////////////////////////////////
	// Forwarding mux selects
	////////////////////////////////////////////////////////////

	localparam logic [selWidth-1:0] fwdNone = 4'd0;

	// Compare operands in decode
	localparam logic [selWidth-1:0] mToDAlu = 4'd1;
	localparam logic [selWidth-1:0] mToDPc  = 4'd2;
	localparam logic [selWidth-1:0] wToDAlu = 4'd3;
	localparam logic [selWidth-1:0] wToDDm  = 4'd4;
	localparam logic [selWidth-1:0] wToDPc  = 4'd5;

	// ALU operands in execute
	localparam logic [selWidth-1:0] mToEAlu = 4'd6;
	localparam logic [selWidth-1:0] mToEPc  = 4'd7;
	localparam logic [selWidth-1:0] wToEAlu = 4'd8;
	localparam logic [selWidth-1:0] wToEDm  = 4'd9;
	localparam logic [selWidth-1:0] wToEPc  = 4'd10;

	// Store data in memory, writeback only
	localparam logic [selWidth-1:0] wToMAlu = 4'd11;
	localparam logic [selWidth-1:0] wToMDm  = 4'd12;
	localparam logic [selWidth-1:0] wToMPc  = 4'd13;

endpackage

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  logic [hazardPkg::instrWidth-1:0] instr,
	output logic [hazardPkg::regIdxW-1:0]    rs,
	output logic [hazardPkg::regIdxW-1:0]    rt,
	output logic [hazardPkg::regIdxW-1:0]    dest,
	output logic [hazardPkg::clsWidth-1:0]   resCls,
	output logic [hazardPkg::useWidth-1:0]   useRs,
	output logic [hazardPkg::useWidth-1:0]   useRt
);
	import hazardPkg::*;

	logic [5:0]         opcode;
	logic [5:0]         funct;
	logic [regIdxW-1:0] fieldRs;
	logic [regIdxW-1:0] fieldRt;
	logic [regIdxW-1:0] fieldRd;

	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign fieldRs = instr[25:21];
	assign fieldRt = instr[20:16];
	assign fieldRd = instr[15:11];

	// Class, destination and operand timing per instruction
	always_comb begin
		dest   = '0;
		resCls = clsNone;
		useRs  = useNever;
		useRt  = useNever;
		case (opcode)
			opRtype: begin
				if (funct == fnAddu || funct == fnSubu) begin
					dest   = fieldRd;
					resCls = clsAlu;
					useRs  = useExe;
					useRt  = useExe;
				end else if (funct == fnJr) begin
					// Jump target compared in decode
					useRs = useNow;
				end
			end
			opOri: begin
				dest   = fieldRt;
				resCls = clsAlu;
				useRs  = useExe;
			end
			opLui: begin
				dest   = fieldRt;
				resCls = clsAlu;
			end
			opLw: begin
				dest   = fieldRt;
				resCls = clsDm;
				useRs  = useExe;
			end
			opSw: begin
				useRs = useExe;
				// Store data not needed before memory
				useRt = useMem;
			end
			opBeq: begin
				useRs = useNow;
				useRt = useNow;
			end
			opJal: begin
				dest   = regLink;
				resCls = clsPc;
			end
			default: begin
				// Anything else behaves as a nop
				dest = '0;
			end
		endcase
	end

	// Unread fields are reported as $0 so they never match a producer
	assign rs = (useRs == useNever) ? '0 : fieldRs;
	assign rt = (useRt == useNever) ? '0 : fieldRt;

endmodule

//--- hw/forwardControl.sv
`timescale 1ns/1ps

module forwardControl (
	input  logic [hazardPkg::regIdxW-1:0]  rsD,
	input  logic [hazardPkg::regIdxW-1:0]  rtD,
	input  logic [hazardPkg::regIdxW-1:0]  rsE,
	input  logic [hazardPkg::regIdxW-1:0]  rtE,
	input  logic [hazardPkg::regIdxW-1:0]  rtM,
	input  logic [hazardPkg::regIdxW-1:0]  destM,
	input  logic [hazardPkg::regIdxW-1:0]  destW,
	input  logic [hazardPkg::clsWidth-1:0] clsM,
	input  logic [hazardPkg::clsWidth-1:0] clsW,
	output logic [hazardPkg::selWidth-1:0] fwdCmp1,
	output logic [hazardPkg::selWidth-1:0] fwdCmp2,
	output logic [hazardPkg::selWidth-1:0] fwdAluA,
	output logic [hazardPkg::selWidth-1:0] fwdAluB,
	output logic [hazardPkg::selWidth-1:0] fwdDm
);
	import hazardPkg::*;

	logic mReady;
	logic wReady;

	// lw in memory has no data yet, only ALU and link results
	assign mReady = (clsM == clsAlu) || (clsM == clsPc);
	assign wReady = (clsW != clsNone);

	////////////////////////////////////////////////////////////
	// Source selection for one operand point
	////////////////////////////////////////////////////////////

	function automatic logic [selWidth-1:0] pickSrc(
		input logic [regIdxW-1:0]  src,
		input logic                checkM,
		input logic [selWidth-1:0] mAlu,
		input logic [selWidth-1:0] mPc,
		input logic [selWidth-1:0] wAlu,
		input logic [selWidth-1:0] wDm,
		input logic [selWidth-1:0] wPc
	);
		logic [selWidth-1:0] sel;
		sel = fwdNone;
		if (src == '0) begin
			sel = fwdNone;
		end else if (checkM && mReady && src == destM) begin
			// Newest value wins over writeback
			sel = (clsM == clsPc) ? mPc : mAlu;
		end else if (wReady && src == destW) begin
			case (clsW)
				clsAlu:  sel = wAlu;
				clsDm:   sel = wDm;
				clsPc:   sel = wPc;
				default: sel = fwdNone;
			endcase
		end
		return sel;
	endfunction

	////////////////////////////////////////////////////////////
	// Operand points
	////////////////////////////////////////////////////////////

	// Branch and jr compare in decode
	assign fwdCmp1 = pickSrc(rsD, 1'b1, mToDAlu, mToDPc, wToDAlu, wToDDm, wToDPc);
	assign fwdCmp2 = pickSrc(rtD, 1'b1, mToDAlu, mToDPc, wToDAlu, wToDDm, wToDPc);

	// ALU inputs in execute
	assign fwdAluA = pickSrc(rsE, 1'b1, mToEAlu, mToEPc, wToEAlu, wToEDm, wToEPc);
	assign fwdAluB = pickSrc(rtE, 1'b1, mToEAlu, mToEPc, wToEAlu, wToEDm, wToEPc);

	// Store data sees only writeback, M slots are never chosen
	assign fwdDm = pickSrc(rtM, 1'b0, fwdNone, fwdNone, wToMAlu, wToMDm, wToMPc);

endmodule

//--- hw/stallControl.sv
`timescale 1ns/1ps

module stallControl (
	input  logic [hazardPkg::regIdxW-1:0]  rsD,
	input  logic [hazardPkg::regIdxW-1:0]  rtD,
	input  logic [hazardPkg::useWidth-1:0] useRsD,
	input  logic [hazardPkg::useWidth-1:0] useRtD,
	input  logic [hazardPkg::regIdxW-1:0]  destE,
	input  logic [hazardPkg::clsWidth-1:0] clsE,
	input  logic [hazardPkg::regIdxW-1:0]  destM,
	input  logic [hazardPkg::clsWidth-1:0] clsM,
	output logic                           stall
);
	import hazardPkg::*;

	// Cycles until each producer result can be forwarded
	logic [1:0] tnewE;
	logic [1:0] tnewM;

	always_comb begin
		case (clsE)
			clsAlu:  tnewE = 2'd1;
			clsDm:   tnewE = 2'd2;
			default: tnewE = 2'd0;
		endcase
	end

	assign tnewM = (clsM == clsDm) ? 2'd1 : 2'd0;

	// One operand against one producer
	function automatic logic needWait(
		input logic [regIdxW-1:0]  src,
		input logic [useWidth-1:0] useT,
		input logic [regIdxW-1:0]  dest,
		input logic [1:0]          tnew
	);
		return (src != '0) && (useT != useNever) && (src == dest) && (useT < tnew);
	endfunction

	logic stallRsE;
	logic stallRtE;
	logic stallRsM;
	logic stallRtM;

	assign stallRsE = needWait(rsD, useRsD, destE, tnewE);
	assign stallRtE = needWait(rtD, useRtD, destE, tnewE);
	assign stallRsM = needWait(rsD, useRsD, destM, tnewM);
	assign stallRtM = needWait(rtD, useRtD, destM, tnewM);

	assign stall = stallRsE | stallRtE | stallRsM | stallRtM;

endmodule

//--- hw/pipeTracker.sv
`timescale 1ns/1ps

module pipeTracker (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [hazardPkg::instrWidth-1:0] instrIn,
	input  logic                             stall,
	output logic [hazardPkg::instrWidth-1:0] instrD,
	output logic [hazardPkg::instrWidth-1:0] instrE,
	output logic [hazardPkg::instrWidth-1:0] instrM,
	output logic [hazardPkg::instrWidth-1:0] instrW
);
	import hazardPkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			instrD <= instrNop;
			instrE <= instrNop;
			instrM <= instrNop;
			instrW <= instrNop;
		end else begin
			// Decode holds its word until the hazard clears
			if (!stall) begin
				instrD <= instrIn;
			end
			// Bubble into execute while decode waits
			instrE <= stall ? instrNop : instrD;
			// Later stages always drain
			instrM <= instrE;
			instrW <= instrM;
		end
	end

endmodule

//--- hw/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [hazardPkg::instrWidth-1:0] instrIn,
	output logic                             stall,
	output logic [hazardPkg::selWidth-1:0]   fwdCmp1,
	output logic [hazardPkg::selWidth-1:0]   fwdCmp2,
	output logic [hazardPkg::selWidth-1:0]   fwdAluA,
	output logic [hazardPkg::selWidth-1:0]   fwdAluB,
	output logic [hazardPkg::selWidth-1:0]   fwdDm
);
	import hazardPkg::*;

	logic [instrWidth-1:0] instrD, instrE, instrM, instrW;

	// Decode stage sources
	logic [regIdxW-1:0]  rsD, rtD;
	logic [useWidth-1:0] useRsD, useRtD;

	// Execute stage
	logic [regIdxW-1:0]  rsE, rtE, destE;
	logic [clsWidth-1:0] clsE;

	// Memory and writeback producers
	logic [regIdxW-1:0]  rtM, destM, destW;
	logic [clsWidth-1:0] clsM, clsW;

	pipeTracker tracker (
		.clk(clk), .reset(reset), .instrIn(instrIn), .stall(stall),
		.instrD(instrD), .instrE(instrE), .instrM(instrM), .instrW(instrW)
	);

	////////////////////////////////////////////////////////////
	// Per-stage decode
	////////////////////////////////////////////////////////////

	instrDecoder decD (
		.instr(instrD), .rs(rsD), .rt(rtD), .dest(), .resCls(),
		.useRs(useRsD), .useRt(useRtD)
	);

	instrDecoder decE (
		.instr(instrE), .rs(rsE), .rt(rtE), .dest(destE), .resCls(clsE),
		.useRs(), .useRt()
	);

	instrDecoder decM (
		.instr(instrM), .rs(), .rt(rtM), .dest(destM), .resCls(clsM),
		.useRs(), .useRt()
	);

	instrDecoder decW (
		.instr(instrW), .rs(), .rt(), .dest(destW), .resCls(clsW),
		.useRs(), .useRt()
	);

	////////////////////////////////////////////////////////////
	// Hazard decisions
	////////////////////////////////////////////////////////////

	forwardControl fwdCtrl (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE), .rtM(rtM),
		.destM(destM), .destW(destW), .clsM(clsM), .clsW(clsW),
		.fwdCmp1(fwdCmp1), .fwdCmp2(fwdCmp2), .fwdAluA(fwdAluA),
		.fwdAluB(fwdAluB), .fwdDm(fwdDm)
	);

	stallControl stallCtrl (
		.rsD(rsD), .rtD(rtD), .useRsD(useRsD), .useRtD(useRtD),
		.destE(destE), .clsE(clsE), .destM(destM), .clsM(clsM),
		.stall(stall)
	);

endmodule

//--- dv/hazardRefModel.svh
`ifndef HAZARD_REF_MODEL_SVH
`define HAZARD_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Expected decode of one instruction word
////////////////////////////////////////////////////////////

function automatic void refDecode(
	input  logic [31:0] w,
	output logic [4:0]  rs,
	output logic [4:0]  rt,
	output logic [4:0]  dest,
	output logic [1:0]  cls,
	output logic [1:0]  useRs,
	output logic [1:0]  useRt
);
	logic aluR;
	logic isJr;
	logic [5:0] op;
	op   = w[31:26];
	aluR = (op == opRtype) && (w[5:0] == fnAddu || w[5:0] == fnSubu);
	isJr = (op == opRtype) && (w[5:0] == fnJr);
	cls  = (aluR || op == opOri || op == opLui) ? clsAlu :
		(op == opLw) ? clsDm : (op == opJal) ? clsPc : clsNone;
	dest = aluR ? w[15:11] : (op == opOri || op == opLui || op == opLw) ? w[20:16] :
		(op == opJal) ? 5'd31 : 5'd0;
	useRs = (op == opBeq || isJr) ? useNow :
		(aluR || op == opOri || op == opLw || op == opSw) ? useExe : useNever;
	useRt = (op == opBeq) ? useNow : aluR ? useExe : (op == opSw) ? useMem : useNever;
	// An operand that is never read behaves like $0
	rs = (useRs == useNever) ? 5'd0 : w[25:21];
	rt = (useRt == useNever) ? 5'd0 : w[20:16];
endfunction

// Cycles until a producer result can be forwarded
function automatic logic [1:0] refTnew(input logic [1:0] cls, input logic inMem);
	if (inMem)
		return (cls == clsDm) ? 2'd1 : 2'd0;
	case (cls)
		clsAlu:  return 2'd1;
		clsDm:   return 2'd2;
		default: return 2'd0;
	endcase
endfunction

function automatic logic refStall(input logic [31:0] d, input logic [31:0] e,
		input logic [31:0] m);
	logic [4:0] rsD, rtD, dD, rsE, rtE, dE, rsM, rtM, dM;
	logic [1:0] cD, cE, cM, uRs, uRt, uA, uB;
	logic [1:0] tE;
	logic [1:0] tM;
	refDecode(d, rsD, rtD, dD, cD, uRs, uRt);
	refDecode(e, rsE, rtE, dE, cE, uA, uB);
	refDecode(m, rsM, rtM, dM, cM, uA, uB);
	tE = refTnew(cE, 1'b0);
	tM = refTnew(cM, 1'b1);
	return (rsD != 0 && ((rsD == dE && uRs < tE) || (rsD == dM && uRs < tM))) ||
		(rtD != 0 && ((rtD == dE && uRt < tE) || (rtD == dM && uRt < tM)));
endfunction

// Select for one operand point; point 0 is decode, 1 execute, 2 memory
function automatic logic [3:0] refSource(input logic [4:0] src, input int point,
		input logic [4:0] dM, input logic [1:0] cM, input logic [4:0] dW,
		input logic [1:0] cW);
	logic [3:0] sel;
	sel = fwdNone;
	if (src != 0 && point != 2 && src == dM && (cM == clsAlu || cM == clsPc)) begin
		if (point == 0)
			sel = (cM == clsPc) ? mToDPc : mToDAlu;
		else
			sel = (cM == clsPc) ? mToEPc : mToEAlu;
	end else if (src != 0 && src == dW && cW != clsNone) begin
		case (point)
			0:       sel = (cW == clsAlu) ? wToDAlu : (cW == clsDm) ? wToDDm : wToDPc;
			1:       sel = (cW == clsAlu) ? wToEAlu : (cW == clsDm) ? wToEDm : wToEPc;
			default: sel = (cW == clsAlu) ? wToMAlu : (cW == clsDm) ? wToMDm : wToMPc;
		endcase
	end
	return sel;
endfunction

function automatic void refSelects(
	input  logic [31:0] d,
	input  logic [31:0] e,
	input  logic [31:0] m,
	input  logic [31:0] w,
	output logic [3:0]  cmp1,
	output logic [3:0]  cmp2,
	output logic [3:0]  aluA,
	output logic [3:0]  aluB,
	output logic [3:0]  dm
);
	logic [4:0] rsD, rtD, dD, rsE, rtE, dE, rsM, rtM, dM, rsW, rtW, dW;
	logic [1:0] cD, cE, cM, cW, uA, uB;
	refDecode(d, rsD, rtD, dD, cD, uA, uB);
	refDecode(e, rsE, rtE, dE, cE, uA, uB);
	refDecode(m, rsM, rtM, dM, cM, uA, uB);
	refDecode(w, rsW, rtW, dW, cW, uA, uB);
	cmp1 = refSource(rsD, 0, dM, cM, dW, cW);
	cmp2 = refSource(rtD, 0, dM, cM, dW, cW);
	aluA = refSource(rsE, 1, dM, cM, dW, cW);
	aluB = refSource(rtE, 1, dM, cM, dW, cW);
	dm   = refSource(rtM, 2, dM, cM, dW, cW);
endfunction

`endif

//--- dv/hazardUnitTb.sv
`timescale 1ns/1ps

module hazardUnitTb;
	import hazardPkg::*;

	`include "hazardRefModel.svh"

	localparam int numRandom     = 300;
	// Words sent by the directed sequences, drains included
	localparam int directedWords = 57;
	// Reset, then at most three cycles in decode per word, then margin
	localparam int cycleLimit = 4 + (directedWords + numRandom + 4) * 3 + 20;

	logic        clk;
	logic        reset;
	logic [31:0] instrIn;
	logic        stall;
	logic [3:0]  fwdCmp1;
	logic [3:0]  fwdCmp2;
	logic [3:0]  fwdAluA;
	logic [3:0]  fwdAluB;
	logic [3:0]  fwdDm;

	// Reference copy of the D/E/M/W registers
	logic [31:0] refD;
	logic [31:0] refE;
	logic [31:0] refM;
	logic [31:0] refW;

	// One bit per select code observed since the last clear
	logic [15:0] seenCmp1 = '0;
	logic [15:0] seenAluA = '0;
	logic [15:0] seenAluB = '0;
	logic [15:0] seenDm   = '0;

	integer seed   = 3;
	int     cycles = 0;

	hazardUnit dut0 (
		.clk(clk), .reset(reset), .instrIn(instrIn), .stall(stall),
		.fwdCmp1(fwdCmp1), .fwdCmp2(fwdCmp2), .fwdAluA(fwdAluA),
		.fwdAluB(fwdAluB), .fwdDm(fwdDm)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout: the run went past %0d cycles", cycleLimit);
			$display("SIMULATION FAILED");
			$fatal(1, "Run did not finish in time");
		end
	end

	////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////

	task automatic checkValue(input string what, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, want);
			$display("SIMULATION FAILED");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	always @(posedge clk) begin : refAdvance
		logic hold;
		hold = refStall(refD, refE, refM);
		if (reset) begin
			refD <= instrNop;
			refE <= instrNop;
			refM <= instrNop;
			refW <= instrNop;
		end else begin
			if (!hold)
				refD <= instrIn;
			refE <= hold ? instrNop : refD;
			refM <= refE;
			refW <= refM;
		end
	end

	// Compare one time unit before each rising edge
	initial begin : compare
		logic [3:0] expCmp1, expCmp2, expAluA, expAluB, expDm;
		forever begin
			@(posedge clk);
			#3;
			refSelects(refD, refE, refM, refW, expCmp1, expCmp2, expAluA, expAluB, expDm);
			checkValue("stall", stall, refStall(refD, refE, refM));
			checkValue("fwdCmp1", fwdCmp1, expCmp1);
			checkValue("fwdCmp2", fwdCmp2, expCmp2);
			checkValue("fwdAluA", fwdAluA, expAluA);
			checkValue("fwdAluB", fwdAluB, expAluB);
			checkValue("fwdDm", fwdDm, expDm);
			seenCmp1[fwdCmp1] = 1'b1;
			seenAluA[fwdAluA] = 1'b1;
			seenAluB[fwdAluB] = 1'b1;
			seenDm[fwdDm]     = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Registers drawn from $0..$3 so that matches are frequent
	function automatic logic [31:0] randomInstr();
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rc;
		logic [15:0] imm;
		logic [31:0] w;
		int          pick;
		pick = $unsigned($random(seed)) % 10;
		ra   = $unsigned($random(seed)) % 4;
		rb   = $unsigned($random(seed)) % 4;
		rc   = $unsigned($random(seed)) % 4;
		imm  = $random(seed);
		case (pick)
			0:       w = encR(ra, rb, rc, fnAddu);
			1:       w = encR(ra, rb, rc, fnSubu);
			2:       w = encI(opOri, ra, rb, imm);
			3:       w = encI(opLui, 5'd0, rb, imm);
			4:       w = encI(opLw, ra, rb, imm);
			5:       w = encI(opSw, ra, rb, imm);
			6:       w = encI(opBeq, ra, rb, imm);
			7:       w = {opJal, 10'd0, imm};
			8:       w = encR(ra, 5'd0, 5'd0, fnJr);
			default: w = instrNop;
		endcase
		return w;
	endfunction

	// Holds the word until decode accepts it
	task automatic send(input logic [31:0] w);
		instrIn = w;
		#2;
		while (stall === 1'b1) begin
			@(posedge clk);
			#3;
		end
		@(posedge clk);
		#1;
	endtask

	// Word then a nop, counting the cycles the word waits in decode
	task automatic issue(input logic [31:0] w, output int waits);
		send(w);
		instrIn = instrNop;
		waits   = 0;
		#2;
		while (stall === 1'b1) begin
			waits++;
			@(posedge clk);
			#3;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic drain();
		repeat (4) send(instrNop);
	endtask

	task automatic clearSeen();
		seenCmp1 = '0;
		seenAluA = '0;
		seenAluB = '0;
		seenDm   = '0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		int waits;
		reset   = 1'b1;
		instrIn = instrNop;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		// Empty pipeline
		checkValue("stall after reset", stall, 1'b0);
		checkValue("fwdCmp1 after reset", fwdCmp1, fwdNone);
		checkValue("fwdCmp2 after reset", fwdCmp2, fwdNone);
		checkValue("fwdAluA after reset", fwdAluA, fwdNone);
		checkValue("fwdAluB after reset", fwdAluB, fwdNone);
		checkValue("fwdDm after reset", fwdDm, fwdNone);

		// Back to back ALU dependency
		clearSeen();
		send(encR(5'd2, 5'd3, 5'd1, fnAddu));
		send(encR(5'd1, 5'd5, 5'd4, fnAddu));
		drain();
		checkValue("addu-addu mToEAlu seen", seenAluA[mToEAlu], 1'b1);
		// One unrelated word in between
		clearSeen();
		send(encR(5'd2, 5'd3, 5'd1, fnAddu));
		send(encI(opOri, 5'd6, 5'd7, 16'h00ff));
		send(encR(5'd5, 5'd1, 5'd4, fnAddu));
		drain();
		checkValue("addu-x-addu wToEAlu seen", seenAluB[wToEAlu], 1'b1);

		// Load-use
		clearSeen();
		send(encI(opLw, 5'd2, 5'd6, 16'h0000));
		issue(encR(5'd6, 5'd3, 5'd7, fnAddu), waits);
		checkValue("lw-addu stall cycles", waits, 1);
		drain();
		checkValue("lw-addu wToEDm seen", seenAluA[wToEDm], 1'b1);
		clearSeen();
		send(encI(opLw, 5'd2, 5'd6, 16'h0000));
		issue(encI(opBeq, 5'd6, 5'd0, 16'h0004), waits);
		checkValue("lw-beq stall cycles", waits, 2);
		drain();
		checkValue("lw-beq wToDDm seen", seenCmp1[wToDDm], 1'b1);

		// Link register into jr
		clearSeen();
		send({opJal, 26'h0000040});
		send(instrNop);
		issue(encR(5'd31, 5'd0, 5'd0, fnJr), waits);
		checkValue("jal-jr stall cycles", waits, 0);
		drain();
		checkValue("jal-jr mToDPc seen", seenCmp1[mToDPc], 1'b1);
		// Store data from a load in writeback
		clearSeen();
		send(encI(opLw, 5'd2, 5'd6, 16'h0000));
		send(encI(opSw, 5'd0, 5'd6, 16'h0004));
		drain();
		checkValue("lw-sw wToMDm seen", seenDm[wToMDm], 1'b1);

		// $0 as destination
		clearSeen();
		send(encR(5'd1, 5'd2, 5'd0, fnAddu));
		send(encR(5'd0, 5'd0, 5'd3, fnAddu));
		send(encI(opLw, 5'd2, 5'd0, 16'h0000));
		issue(encI(opBeq, 5'd0, 5'd0, 16'h0004), waits);
		checkValue("lw $0 then beq stall cycles", waits, 0);
		drain();
		checkValue("$0 fwdCmp1 codes", seenCmp1, 16'h0001);
		checkValue("$0 fwdAluA codes", seenAluA, 16'h0001);
		checkValue("$0 fwdAluB codes", seenAluB, 16'h0001);
		checkValue("$0 fwdDm codes", seenDm, 16'h0001);
		// Memory over writeback
		clearSeen();
		send(encR(5'd2, 5'd3, 5'd1, fnAddu));
		send(encI(opOri, 5'd2, 5'd1, 16'h0005));
		send(encR(5'd1, 5'd0, 5'd4, fnAddu));
		drain();
		checkValue("M priority mToEAlu seen", seenAluA[mToEAlu], 1'b1);
		checkValue("M priority wToEAlu seen", seenAluA[wToEAlu], 1'b0);

		for (int i = 0; i < numRandom; i++)
			send(randomInstr());
		drain();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+dv
hw/hazardPkg.sv
hw/instrDecoder.sv
hw/forwardControl.sv
hw/stallControl.sv
hw/pipeTracker.sv
hw/hazardUnit.sv
dv/hazardUnitTb.sv

//--- Bender.yml
package:
  name: hazard_unit

sources:
  - files:
      - hw/hazardPkg.sv
      - hw/instrDecoder.sv
      - hw/forwardControl.sv
      - hw/stallControl.sv
      - hw/pipeTracker.sv
      - hw/hazardUnit.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/hazardUnitTb.sv
